// File: mem_defs.svh
// Sizes are fixed; load and store lane logic assumes a 32-bit word of four bytes
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Data word width in bits
`define MEM_DATA_W 32

// Word address width, gives the depth below
`define MEM_WADDR_W 5

// Byte address adds the two lane bits
`define MEM_BADDR_W (`MEM_WADDR_W + 2)

// Words held in the data memory
`define MEM_DEPTH 32

`endif

// File: mem_pkg.sv
// Shared types for the memory stage; size code 2'b10 is not named and is handled as a word
`include "mem_defs.svh"

package mem_pkg;

    // Plain vectors with a meaning
    typedef logic [`MEM_DATA_W-1:0]  word_t;
    typedef logic [`MEM_BADDR_W-1:0] baddr_t;
    typedef logic [`MEM_WADDR_W-1:0] waddr_t;

    // One write enable per byte lane, bit 0 is bits 7..0
    typedef logic [3:0] lane_en_t;

    // Access size codes of the load/store unit
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b11
    } access_size_e;

    // Load or store request, 43 bits
    typedef struct packed {
        logic         write;        // Store when set
        access_size_e size;
        logic         is_unsigned;  // Zero-extend loads
        baddr_t       addr;         // Byte address
        word_t        wdata;        // Store data, low bits used
    } mem_req_t;

    // Debug dump sequencer
    typedef enum logic {
        DUMP_IDLE = 1'b0,
        DUMP_RUN  = 1'b1
    } dump_state_e;

endpackage

// File: store_align.sv
// Purely combinational; misaligned halfword and word addresses are truncated, never trapped
module store_align (
    input  mem_pkg::access_size_e i_size,
    input  logic [1:0]            i_addr_lo,
    input  mem_pkg::word_t        i_wdata,
    output mem_pkg::lane_en_t     o_lane_en,
    output mem_pkg::word_t        o_wdata
);

    mem_pkg::word_t    wdata_byte;
    mem_pkg::word_t    wdata_half;
    mem_pkg::lane_en_t lane_byte;
    mem_pkg::lane_en_t lane_half;

    // Low byte copied into every lane
    assign wdata_byte = {4{i_wdata[7:0]}};

    // Low halfword copied into both halves
    assign wdata_half = {2{i_wdata[15:0]}};

    // One lane per byte address
    always_comb
    begin
        case (i_addr_lo)
            2'b00:   lane_byte = 4'b0001;
            2'b01:   lane_byte = 4'b0010;
            2'b10:   lane_byte = 4'b0100;
            default: lane_byte = 4'b1000;
        endcase
    end

    // Address bit 0 has no effect on halfwords
    assign lane_half = i_addr_lo[1] ? 4'b1100 : 4'b0011;

    always_comb
    begin
        case (i_size)
            mem_pkg::SIZE_BYTE:
            begin
                o_lane_en = lane_byte;
                o_wdata   = wdata_byte;
            end
            mem_pkg::SIZE_HALF:
            begin
                o_lane_en = lane_half;
                o_wdata   = wdata_half;
            end
            default:    // Word, also code 2'b10
            begin
                o_lane_en = 4'b1111;
                o_wdata   = i_wdata;
            end
        endcase
    end

endmodule

// File: load_extend.sv
// Combinational load formatter; address bits below the access size are ignored
`include "mem_defs.svh"

module load_extend (
    input  mem_pkg::word_t        i_word,
    input  mem_pkg::access_size_e i_size,
    input  logic                  i_is_unsigned,
    input  logic [1:0]            i_addr_lo,
    output mem_pkg::word_t        o_data
);

    logic [7:0]     byte_sel;
    logic [15:0]    half_sel;
    logic           byte_fill;
    logic           half_fill;
    mem_pkg::word_t byte_ext;
    mem_pkg::word_t half_ext;

    // Addressed byte moved down to bit 0
    always_comb
    begin
        case (i_addr_lo)
            2'b00:   byte_sel = i_word[7:0];
            2'b01:   byte_sel = i_word[15:8];
            2'b10:   byte_sel = i_word[23:16];
            default: byte_sel = i_word[31:24];
        endcase
    end

    assign half_sel = i_addr_lo[1] ? i_word[31:16] : i_word[15:0];  // Bit 0 unused

    // Top bit of the field for signed loads, zero otherwise
    assign byte_fill = byte_sel[7] & ~i_is_unsigned;
    assign half_fill = half_sel[15] & ~i_is_unsigned;

    assign byte_ext = {{(`MEM_DATA_W - 8){byte_fill}}, byte_sel};
    assign half_ext = {{(`MEM_DATA_W - 16){half_fill}}, half_sel};

    always_comb
    begin
        case (i_size)
            mem_pkg::SIZE_BYTE:
            begin
                o_data = byte_ext;
            end
            mem_pkg::SIZE_HALF:
            begin
                o_data = half_ext;
            end
            default:
            begin
                o_data = i_word;    // Word passes unchanged
            end
        endcase
    end

endmodule

// File: data_mem.sv
// Contents start at zero and survive reset; both read ports are asynchronous
`include "mem_defs.svh"

module data_mem (
    input  logic              i_clk,
    input  logic              i_write,
    input  mem_pkg::waddr_t   i_addr,
    input  mem_pkg::lane_en_t i_lane_en,
    input  mem_pkg::word_t    i_wdata,
    input  mem_pkg::waddr_t   i_debug_addr,
    output mem_pkg::word_t    o_rdata,
    output mem_pkg::word_t    o_debug_data
);

    mem_pkg::word_t mem_array [`MEM_DEPTH];

    // Power-up contents
    initial
    begin
        for (int w = 0; w < `MEM_DEPTH; w++)
        begin
            mem_array[w] = '0;
        end
    end

    // Lane-enabled write, other lanes keep their bytes
    always_ff @(posedge i_clk)
    begin
        if (i_write)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (i_lane_en[lane])
                begin
                    mem_array[i_addr][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Access path read, seen in the same cycle
    assign o_rdata = mem_array[i_addr];

    // Debugger read
    assign o_debug_data = mem_array[i_debug_addr];

endmodule

// File: debug_dump.sv
// No back-pressure: each beat must be taken while o_valid is high; start is ignored when busy
`include "mem_defs.svh"

module debug_dump (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_start,
    input  mem_pkg::word_t  i_mem_data,
    output mem_pkg::waddr_t o_mem_addr,
    output logic            o_valid,
    output logic            o_done,
    output mem_pkg::waddr_t o_addr,
    output mem_pkg::word_t  o_data
);

    localparam mem_pkg::waddr_t LAST_WORD = mem_pkg::waddr_t'(`MEM_DEPTH - 1);

    mem_pkg::dump_state_e state;
    mem_pkg::dump_state_e state_next;
    mem_pkg::waddr_t      word_cnt;
    mem_pkg::waddr_t      word_cnt_next;
    logic                 running;
    logic                 at_last;

    assign running = (state == mem_pkg::DUMP_RUN);
    assign at_last = (word_cnt == LAST_WORD);

    // Next state and counter
    always_comb
    begin
        state_next    = state;
        word_cnt_next = word_cnt;
        case (state)
            mem_pkg::DUMP_IDLE:
            begin
                if (i_start)
                begin
                    state_next    = mem_pkg::DUMP_RUN;
                    word_cnt_next = '0;  // Always start from word 0
                end
            end
            mem_pkg::DUMP_RUN:
            begin
                if (at_last)
                begin
                    state_next = mem_pkg::DUMP_IDLE;
                end
                else
                begin
                    word_cnt_next = word_cnt + 1'b1;
                end
            end
            default:
            begin
                state_next = mem_pkg::DUMP_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state    <= mem_pkg::DUMP_IDLE;
            word_cnt <= '0;
        end
        else
        begin
            state    <= state_next;
            word_cnt <= word_cnt_next;
        end
    end

    // One beat per cycle while running
    assign o_mem_addr = word_cnt;
    assign o_valid    = running;
    assign o_done     = running & at_last;  // Only with the last word
    assign o_addr     = word_cnt;
    assign o_data     = i_mem_data;         // Memory word current this cycle

endmodule

// File: mem_stage.sv
// Memory-access stage; loads return in the same cycle, no handshake and no misalignment traps
`include "mem_defs.svh"

module mem_stage (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  mem_pkg::mem_req_t i_req,
    input  logic              i_dump_start,
    output mem_pkg::word_t    o_rdata,
    output logic              o_dump_valid,
    output logic              o_dump_done,
    output mem_pkg::waddr_t   o_dump_addr,
    output mem_pkg::word_t    o_dump_data
);

    mem_pkg::waddr_t   req_waddr;
    mem_pkg::lane_en_t st_lane_en;
    mem_pkg::word_t    st_wdata;
    mem_pkg::word_t    mem_rdata;
    mem_pkg::waddr_t   dbg_addr;
    mem_pkg::word_t    dbg_data;

    assign req_waddr = i_req.addr[`MEM_BADDR_W-1:2];  // Drop the lane bits

    store_align u_store_align (
        .i_size    (i_req.size),
        .i_addr_lo (i_req.addr[1:0]),
        .i_wdata   (i_req.wdata),
        .o_lane_en (st_lane_en),
        .o_wdata   (st_wdata)
    );

    data_mem u_data_mem (
        .i_clk        (i_clk),
        .i_write      (i_req.write),
        .i_addr       (req_waddr),
        .i_lane_en    (st_lane_en),
        .i_wdata      (st_wdata),
        .i_debug_addr (dbg_addr),
        .o_rdata      (mem_rdata),
        .o_debug_data (dbg_data)
    );

    load_extend u_load_extend (
        .i_word        (mem_rdata),
        .i_size        (i_req.size),
        .i_is_unsigned (i_req.is_unsigned),
        .i_addr_lo     (i_req.addr[1:0]),
        .o_data        (o_rdata)
    );

    debug_dump u_debug_dump (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_dump_start),
        .i_mem_data (dbg_data),
        .o_mem_addr (dbg_addr),
        .o_valid    (o_dump_valid),
        .o_done     (o_dump_done),
        .o_addr     (o_dump_addr),
        .o_data     (o_dump_data)
    );

endmodule

// File: tb_mem_stage.sv
// Checks only values the testbench stored itself; dump beats are taken every cycle
`include "mem_defs.svh"

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_HALF     = 2;
    localparam int CLK_PERIOD   = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_BYTES    = `MEM_DEPTH * 4;
    localparam int NUM_TESTS    = 6;

    typedef enum logic [1:0] {
        OP_STORE,
        OP_LOAD,
        OP_DUMP
    } op_e;

    // One table row; exp is used only when has_exp is set
    typedef struct packed {
        int                    test;
        op_e                   op;
        mem_pkg::access_size_e size;
        logic                  is_unsigned;
        mem_pkg::baddr_t       addr;
        mem_pkg::word_t        data;
        logic                  has_exp;
        mem_pkg::word_t        exp;
    } entry_t;

    logic              clk;
    logic              rst_n;
    mem_pkg::mem_req_t req;
    logic              dump_start;
    mem_pkg::word_t    rdata;
    logic              dump_valid;
    logic              dump_done;
    mem_pkg::waddr_t   dump_addr;
    mem_pkg::word_t    dump_data;

    logic [7:0] model_mem [NUM_BYTES];  // Byte-wide reference memory
    entry_t     table_q [$];
    int         check_count;
    int         err_count;
    int         test_err;
    int         tests_ok;
    int         run_limit_ns;

    mem_stage u_mem_stage (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_req        (req),
        .i_dump_start (dump_start),
        .o_rdata      (rdata),
        .o_dump_valid (dump_valid),
        .o_dump_done  (dump_done),
        .o_dump_addr  (dump_addr),
        .o_dump_data  (dump_data)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic check_value(input string name, input mem_pkg::word_t got,
                               input mem_pkg::word_t exp);
        check_count++;
        assert (got === exp)
        else
        begin
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
            err_count++;
            test_err++;
        end
    endtask

    task automatic add_entry(input int test, input op_e op, input mem_pkg::access_size_e size,
                             input logic uns, input mem_pkg::baddr_t addr,
                             input mem_pkg::word_t data, input logic has_exp,
                             input mem_pkg::word_t exp);
        entry_t e;
        e = '{test, op, size, uns, addr, data, has_exp, exp};
        table_q.push_back(e);
    endtask

    // Byte stores write one byte, halfwords align down to even, words to a multiple of 4
    task automatic model_store(input mem_pkg::access_size_e size, input mem_pkg::baddr_t addr,
                               input mem_pkg::word_t data);
        case (size)
            mem_pkg::SIZE_BYTE: model_mem[addr] = data[7:0];
            mem_pkg::SIZE_HALF:
            begin
                model_mem[{addr[`MEM_BADDR_W-1:1], 1'b0}] = data[7:0];
                model_mem[{addr[`MEM_BADDR_W-1:1], 1'b1}] = data[15:8];
            end
            default:
            begin
                for (int b = 0; b < 4; b++)
                begin
                    model_mem[{addr[`MEM_BADDR_W-1:2], 2'(b)}] = data[b*8 +: 8];
                end
            end
        endcase
    endtask

    function automatic mem_pkg::word_t model_word(input mem_pkg::waddr_t w);
        return {model_mem[{w, 2'd3}], model_mem[{w, 2'd2}], model_mem[{w, 2'd1}],
                model_mem[{w, 2'd0}]};
    endfunction

    function automatic mem_pkg::word_t model_load(input mem_pkg::access_size_e size,
                                                  input logic uns, input mem_pkg::baddr_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = model_mem[addr];
        h = {model_mem[{addr[`MEM_BADDR_W-1:1], 1'b1}], model_mem[{addr[`MEM_BADDR_W-1:1], 1'b0}]};
        case (size)
            mem_pkg::SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
            mem_pkg::SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:            return model_word(addr[`MEM_BADDR_W-1:2]);
        endcase
    endfunction

    // Each byte carries the full word address under a per-lane tag
    function automatic mem_pkg::word_t fill_word(input mem_pkg::waddr_t w);
        return {3'b101, w, 3'b110, w, 3'b011, w, 3'b100, w};
    endfunction

    task automatic build_table();
        logic [31:0] r;
        // Every word gets a known value before any load or dump
        for (int w = 0; w < `MEM_DEPTH; w++)
        begin
            add_entry(1, OP_STORE, mem_pkg::SIZE_WORD, 0, {mem_pkg::waddr_t'(w), 2'b00},
                      fill_word(mem_pkg::waddr_t'(w)), 0, '0);
        end
        // Word store and load with nonzero low address bits
        add_entry(1, OP_STORE, mem_pkg::SIZE_WORD, 0, 7'h04, 32'hDEADBEEF, 0, '0);
        add_entry(1, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h07, 32'h0, 1, 32'hDEADBEEF);
        add_entry(1, OP_STORE, mem_pkg::SIZE_WORD, 0, 7'h1D, 32'h01234567, 0, '0);
        add_entry(1, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h1C, 32'h0, 1, 32'h01234567);
        // One byte per lane with junk in the upper data bits
        add_entry(2, OP_STORE, mem_pkg::SIZE_BYTE, 0, 7'h08, 32'hABCDEF11, 0, '0);
        add_entry(2, OP_STORE, mem_pkg::SIZE_BYTE, 0, 7'h09, 32'h00000022, 0, '0);
        add_entry(2, OP_STORE, mem_pkg::SIZE_BYTE, 0, 7'h0A, 32'h12345633, 0, '0);
        add_entry(2, OP_STORE, mem_pkg::SIZE_BYTE, 0, 7'h0B, 32'h000000F4, 0, '0);
        add_entry(2, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h08, 32'h0, 1, 32'hF4332211);
        add_entry(2, OP_LOAD,  mem_pkg::SIZE_BYTE, 0, 7'h0B, 32'h0, 1, 32'hFFFFFFF4);
        add_entry(2, OP_LOAD,  mem_pkg::SIZE_BYTE, 1, 7'h0B, 32'h0, 1, 32'h000000F4);
        add_entry(2, OP_LOAD,  mem_pkg::SIZE_BYTE, 0, 7'h08, 32'h0, 1, 32'h00000011);
        // Halfwords where bit 0 of the address has no effect
        add_entry(3, OP_STORE, mem_pkg::SIZE_HALF, 0, 7'h10, 32'h12348765, 0, '0);
        add_entry(3, OP_STORE, mem_pkg::SIZE_HALF, 0, 7'h13, 32'hFFFFA5C3, 0, '0);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h10, 32'h0, 1, 32'hA5C38765);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_HALF, 0, 7'h11, 32'h0, 1, 32'hFFFF8765);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_HALF, 1, 7'h10, 32'h0, 1, 32'h00008765);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_HALF, 0, 7'h12, 32'h0, 1, 32'hFFFFA5C3);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_HALF, 1, 7'h13, 32'h0, 1, 32'h0000A5C3);
        add_entry(3, OP_STORE, mem_pkg::SIZE_HALF, 0, 7'h16, 32'h00004321, 0, '0);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_HALF, 0, 7'h17, 32'h0, 1, 32'h00004321);
        add_entry(3, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h14, 32'h0, 1, 32'h43216585);
        // Loads carrying store data must not write
        add_entry(4, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h04, 32'hFFFFFFFF, 1, 32'hDEADBEEF);
        add_entry(4, OP_LOAD,  mem_pkg::SIZE_BYTE, 1, 7'h09, 32'h000000FF, 1, 32'h00000022);
        add_entry(4, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h04, 32'h0, 1, 32'hDEADBEEF);
        add_entry(4, OP_LOAD,  mem_pkg::SIZE_WORD, 0, 7'h08, 32'h0, 1, 32'hF4332211);
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            r = $urandom;
            add_entry(5, r[0] ? OP_STORE : OP_LOAD, mem_pkg::access_size_e'(r[2:1]), r[3],
                      r[10:4], $urandom, 0, '0);
        end
        add_entry(6, OP_DUMP, mem_pkg::SIZE_WORD, 0, '0, '0, 0, '0);
    endtask

    // Called on a falling edge; beats are sampled on the following falling edges
    task automatic run_dump();
        req.write  = 1'b0;
        dump_start = 1'b1;
        #1;
        check_value("o_dump_valid", 32'(dump_valid), 32'h0);  // Not before the start edge
        for (int beat = 0; beat < `MEM_DEPTH; beat++)
        begin
            @(negedge clk);
            dump_start = (beat == 4);  // Second pulse while busy
            check_value("o_dump_valid", 32'(dump_valid), 32'h1);
            check_value("o_dump_addr", 32'(dump_addr), 32'(beat));
            check_value("o_dump_data", dump_data, model_word(mem_pkg::waddr_t'(beat)));
            check_value("o_dump_done", 32'(dump_done), 32'(beat == `MEM_DEPTH - 1));
        end
        dump_start = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            check_value("o_dump_valid", 32'(dump_valid), 32'h0);
            check_value("o_dump_done", 32'(dump_done), 32'h0);
        end
    endtask

    task automatic apply_entry(input entry_t e);
        @(negedge clk);
        req.write       = (e.op == OP_STORE);
        req.size        = e.size;
        req.is_unsigned = e.is_unsigned;
        req.addr        = e.addr;
        req.wdata       = e.data;
        case (e.op)
            OP_STORE: model_store(e.size, e.addr, e.data);
            OP_LOAD:
            begin
                #1;
                check_value("o_rdata", rdata,
                            e.has_exp ? e.exp : model_load(e.size, e.is_unsigned, e.addr));
            end
            default: run_dump();
        endcase
    endtask

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset and word access";
            2:       return "byte lanes and byte extension";
            3:       return "halfword access";
            4:       return "loads leave memory unchanged";
            5:       return "random accesses";
            default: return "debug dump";
        endcase
    endfunction

    task automatic report_test(input int n);
        if (test_err == 0)
        begin
            tests_ok++;
            $display("Test %0d (%s): ok", n, test_name(n));
        end
        else
        begin
            $display("Test %0d (%s): %0d errors", n, test_name(n), test_err);
        end
        test_err = 0;
    endtask

    initial
    begin : watchdog
        wait (run_limit_ns != 0);
        #(run_limit_ns);
        $display("Timeout: the run did not finish within %0d ns", run_limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        int cur_test;
        void'($urandom(32'h90ed));
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        dump_start = 1'b0;
        build_table();
        // Table rows plus dump beats with a factor of two margin
        run_limit_ns = (RESET_CYCLES + table_q.size() + `MEM_DEPTH + 10) * CLK_PERIOD * 2;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("o_dump_valid", 32'(dump_valid), 32'h0);
        check_value("o_dump_done", 32'(dump_done), 32'h0);
        cur_test = table_q[0].test;
        foreach (table_q[i])
        begin
            if (table_q[i].test != cur_test)
            begin
                report_test(cur_test);
                cur_test = table_q[i].test;
            end
            apply_entry(table_q[i]);
        end
        report_test(cur_test);
        $display("Tests passed %0d of %0d, checks %0d, errors %0d",
                 tests_ok, NUM_TESTS, check_count, err_count);
        if (err_count == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
mem_pkg.sv
store_align.sv
load_extend.sv
data_mem.sv
debug_dump.sv
mem_stage.sv
tb_mem_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log
TOP=tb_mem_stage

verilator --binary --timing --assert \
    -f sources.f \
    --top-module "$TOP" \
    -o "$TOP"

./obj_dir/"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation passed"
